// ==== files.f ====
hw/mailbox_pkg.sv
hw/dualport_ram.sv
hw/gray_sync.sv
hw/async_fifo.sv
hw/axil_fifo_writer.sv
hw/rr_drain_arbiter.sv
hw/cdc_mailbox_top.sv
verification/cdc_mailbox_props.sv
verification/tb_cdc_mailbox.sv

// ==== Makefile ====
TOP := tb_cdc_mailbox

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== verification/tb_cdc_mailbox.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cdc_mailbox;
  import mailbox_pkg::*;

  localparam int settle = 10;
  localparam int write_wait = 200;
  localparam int block_wait = 40;
  localparam int test1_words = 8;
  localparam int test2_words = 40;
  localparam int test3_words = 20;
  localparam int test4_words = fifo_depth + 1;
  localparam int total_words = test1_words + test2_words + test3_words + test4_words + 2;
  localparam int timeout_cycles = 8 * total_words + 2000;

  logic                       wr_clk;
  logic                       wr_rst_n;
  logic                       rd_clk;
  logic                       rd_rst_n;
  logic                       awvalid;
  logic                       awready;
  logic [axil_addr_width-1:0] awaddr;
  logic                       wvalid;
  logic                       wready;
  logic [31:0]                wdata;
  logic                       bvalid;
  logic                       bready;
  logic [1:0]                 bresp;
  logic                       arvalid;
  logic                       arready;
  logic [axil_addr_width-1:0] araddr;
  logic                       rvalid;
  logic                       rready;
  logic [31:0]                rdata;
  logic [1:0]                 rresp;
  logic                       out_valid;
  logic                       out_ready;
  out_item_t                  out_item;

  logic [data_width-1:0] exp_q0 [$];
  logic [data_width-1:0] exp_q1 [$];
  logic [31:0]           data_rng;
  logic [31:0]           stall_rng;
  int                    stall_mode = 0;          // 0 always ready, 1 random, 2 held low.
  int                    data_errors = 0;
  int                    resp_errors = 0;
  int                    status_errors = 0;
  int                    cycle_count = 0;

  cdc_mailbox_top DUT (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ==================================================
  // reference model
  // ==================================================
  function automatic void record_write(input logic [axil_addr_width-1:0] addr,
                                       input logic [data_width-1:0] data);
    if (addr == reg_chan0) begin
      exp_q0.push_back(data);
    end else if (addr == reg_chan1) begin
      exp_q1.push_back(data);
    end
  endfunction

  function automatic logic [31:0] expected_status(input int held0, input int held1);
    status_t s;
    s.ch0.full = (held0 >= fifo_depth);
    s.ch0.afull = (held0 >= fifo_afull);
    s.ch1.full = (held1 >= fifo_depth);
    s.ch1.afull = (held1 >= fifo_afull);
    return {{(32 - $bits(status_t)){1'b0}}, s};
  endfunction

  // ==================================================
  // clocks and read side reset
  // ==================================================
  initial begin
    wr_clk = 1'b0;
    forever #50 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #65 rd_clk = ~rd_clk;
  end

  initial begin
    rd_rst_n = 1'b0;
    repeat (2) @(negedge rd_clk);
    rd_rst_n = 1'b1;
  end

  initial begin
    out_ready = 1'b0;
    stall_rng = 32'h4371;
    forever begin
      @(negedge rd_clk);
      if (stall_mode == 0) begin
        out_ready = 1'b1;
      end else if (stall_mode == 2) begin
        out_ready = 1'b0;
      end else begin
        stall_rng = xorshift(stall_rng);
        out_ready = stall_rng[0] | stall_rng[1];  // ready about three cycles in four.
      end
    end
  end

  // ==================================================
  // AXI4-Lite host tasks
  // ==================================================
  task automatic axi_write(input logic [axil_addr_width-1:0] addr,
                           input logic [data_width-1:0] data, input int limit,
                           output logic accepted);
    logic       hit;
    logic [1:0] got_resp;
    logic [1:0] want_resp;
    int         waited;
    accepted = 1'b0;
    waited = 0;
    @(negedge wr_clk);
    awaddr = addr;
    wdata = {{(32 - data_width){1'b0}}, data};
    awvalid = 1'b1;
    wvalid = 1'b1;
    while (!accepted && waited < limit) begin
      #settle;
      hit = awready && wready;                    // stable until the next rising edge.
      @(posedge wr_clk);
      accepted = hit;
      waited++;
      @(negedge wr_clk);
    end
    awvalid = 1'b0;
    wvalid = 1'b0;
    if (accepted) begin
      record_write(addr, data);
      bready = 1'b1;
      while (!bvalid) @(negedge wr_clk);
      got_resp = bresp;
      @(negedge wr_clk);
      bready = 1'b0;
      want_resp = (addr == reg_chan0 || addr == reg_chan1) ? resp_okay : resp_slverr;
      assert (got_resp == want_resp) else begin
        $display("FAILED %0t: bresp %0d for address %h, expected %0d",
                 $time, got_resp, addr, want_resp);
        resp_errors++;
      end
    end
  endtask

  task automatic axi_read(input logic [axil_addr_width-1:0] addr,
                          output logic [31:0] data, output logic [1:0] resp);
    @(negedge wr_clk);
    araddr = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge wr_clk);
    @(negedge wr_clk);
    arvalid = 1'b0;
    rready = 1'b1;
    while (!rvalid) @(negedge wr_clk);
    data = rdata;
    resp = rresp;
    assert (!arready) else begin
      $display("arready stayed high while a read response was pending");
      resp_errors++;
    end
    @(negedge wr_clk);
    rready = 1'b0;
  endtask

  task automatic write_word(input int chan);
    logic ok;
    data_rng = xorshift(data_rng);
    axi_write(chan == 0 ? reg_chan0 : reg_chan1, data_rng[data_width-1:0], write_wait, ok);
    assert (ok) else begin
      $display("write to channel %0d was never accepted", chan);
      resp_errors++;
    end
  endtask

  task automatic check_status(input int held0, input int held1);
    logic [31:0] word;
    logic [1:0]  resp;
    axi_read(reg_status, word, resp);
    assert (resp == resp_okay && word == expected_status(held0, held1)) else begin
      $display("FAILED %0t: status %h resp %0d, expected %h resp 0",
               $time, word, resp, expected_status(held0, held1));
      status_errors++;
    end
  endtask

  task automatic wait_drained();
    while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge wr_clk);
  endtask

  // ==================================================
  // output comparator
  // ==================================================
  task automatic check_item(input out_item_t item);
    logic [data_width-1:0] want;
    int                    pending;
    pending = (item.chan == 1'b0) ? exp_q0.size() : exp_q1.size();
    assert (pending > 0) else begin
      $display("unexpected output item on channel %0d at %0t", item.chan, $time);
      data_errors++;
    end
    if (pending > 0) begin
      if (item.chan == 1'b0) begin
        want = exp_q0.pop_front();
      end else begin
        want = exp_q1.pop_front();
      end
      assert (item.data == want) else begin
        $display("FAILED %0t: channel %0d data %h, expected %h",
                 $time, item.chan, item.data, want);
        data_errors++;
      end
    end
  endtask

  initial begin
    logic      held;
    out_item_t held_item;
    held = 1'b0;
    forever begin
      @(negedge rd_clk);
      #settle;                                    // outputs and out_ready are settled here.
      if (held) begin
        assert (out_valid && out_item == held_item) else begin
          $display("FAILED %0t: out_item changed while stalled", $time);
          data_errors++;
        end
      end
      held = out_valid && !out_ready;
      held_item = out_item;
      if (out_valid && out_ready) begin
        check_item(out_item);
      end
    end
  end

  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge wr_clk);
      cycle_count++;
    end
    $display("the run timed out after %0d wr_clk cycles", cycle_count);
    $display("RESULT: FAIL");
    $finish;
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    logic        ok;
    logic [31:0] rd_word;
    logic [1:0]  rd_resp;
    int          accepted;
    int          assert_errors;
    wr_rst_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    data_rng = 32'h4371;
    repeat (2) @(negedge wr_clk);
    wr_rst_n = 1'b1;
    wait (rd_rst_n);
    @(negedge wr_clk);
    assert (!awready && !wready && arready && !bvalid && !rvalid && !out_valid) else begin
      $display("handshake outputs are not idle after reset");
      resp_errors++;
    end

    repeat (test1_words) write_word(0);
    wait_drained();

    stall_mode = 1;
    repeat (test2_words) write_word(int'(data_rng[9]));
    wait_drained();

    // the fifo holds fifo_depth words and the output register one more.
    stall_mode = 2;
    accepted = 0;
    for (int i = 0; i < test3_words; i++) begin
      data_rng = xorshift(data_rng);
      axi_write(reg_chan1, data_rng[data_width-1:0], block_wait, ok);
      if (!ok) break;
      accepted++;
    end
    assert (accepted == fifo_depth + 1) else begin
      $display("FAILED %0t: %0d writes accepted under stall, expected %0d",
               $time, accepted, fifo_depth + 1);
      resp_errors++;
    end
    stall_mode = 0;
    for (int i = accepted; i < test3_words; i++) write_word(1);
    wait_drained();

    stall_mode = 2;
    repeat (fifo_afull + 1) write_word(0);
    while (!out_valid) @(negedge wr_clk);
    repeat (8) @(negedge wr_clk);                 // lets the pop reach the write side.
    check_status(fifo_afull, 0);
    repeat (test4_words - fifo_afull - 1) write_word(0);
    check_status(fifo_depth, 0);
    stall_mode = 0;
    wait_drained();

    axi_write(4'hC, 16'hdead, write_wait, ok);
    assert (ok) else begin
      $display("write to an unused address was never answered");
      resp_errors++;
    end
    axi_read(4'hC, rd_word, rd_resp);
    assert (rd_resp == resp_slverr && rd_word == 32'h0) else begin
      $display("FAILED %0t: unused read gave %h resp %0d", $time, rd_word, rd_resp);
      resp_errors++;
    end
    write_word(0);
    wait_drained();

    assert_errors = DUT.g_chan[0].u_fifo.u_props.fail_count
                  + DUT.g_chan[1].u_fifo.u_props.fail_count;
    $display("errors: data %0d, response %0d, status %0d, assertion %0d",
             data_errors, resp_errors, status_errors, assert_errors);
    if (data_errors + resp_errors + status_errors + assert_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/cdc_mailbox_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module cdc_mailbox_props (
  input wire                            wr_clk,
  input wire                            wr_rst_n,
  input wire                            push,
  input wire mailbox_pkg::fifo_flags_t  flags,
  input wire                            rd_clk,
  input wire                            rd_rst_n,
  input wire                            pop,
  input wire                            empty
);

  int unsigned fail_count = 0;

  // ==================================================
  // write side
  // ==================================================
  a_push_not_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    push |-> !flags.full)
    else begin
      $error("push issued while the fifo is full");
      fail_count++;
    end

  a_flags_after_reset: assert property (@(posedge wr_clk)
    $rose(wr_rst_n) |=> !flags.full && !flags.afull)
    else begin
      $error("full flags set when write reset is released");
      fail_count++;
    end

  // ==================================================
  // read side
  // ==================================================
  a_pop_not_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    pop |-> !empty)
    else begin
      $error("pop issued while the fifo is empty");
      fail_count++;
    end

  a_empty_after_reset: assert property (@(posedge rd_clk)
    $rose(rd_rst_n) |=> empty)
    else begin
      $error("empty clear when read reset is released");
      fail_count++;
    end

endmodule

bind async_fifo cdc_mailbox_props u_props (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .push     (push),
  .flags    (flags),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .pop      (pop),
  .empty    (empty)
);

`default_nettype wire

// ==== hw/cdc_mailbox_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cdc_mailbox_top (
  input  wire                                     wr_clk,
  input  wire                                     wr_rst_n,
  input  wire                                     rd_clk,
  input  wire                                     rd_rst_n,
  input  wire                                     awvalid,
  output logic                                    awready,
  input  wire [mailbox_pkg::axil_addr_width-1:0]  awaddr,
  input  wire                                     wvalid,
  output logic                                    wready,
  input  wire [31:0]                              wdata,
  output logic                                    bvalid,
  input  wire                                     bready,
  output logic [1:0]                              bresp,
  input  wire                                     arvalid,
  output logic                                    arready,
  input  wire [mailbox_pkg::axil_addr_width-1:0]  araddr,
  output logic                                    rvalid,
  input  wire                                     rready,
  output logic [31:0]                             rdata,
  output logic [1:0]                              rresp,
  output logic                                    out_valid,
  input  wire                                     out_ready,
  output mailbox_pkg::out_item_t                  out_item
);
  import mailbox_pkg::*;

  logic [num_chan-1:0] push;
  logic [num_chan-1:0] pop;
  logic [num_chan-1:0] empty;
  chan_word_t          push_data;
  chan_word_t          pop_data [num_chan];
  fifo_flags_t         chan_flags [num_chan];

  axil_fifo_writer u_writer (
    .wr_clk     (wr_clk),
    .wr_rst_n   (wr_rst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .push       (push),
    .push_data  (push_data),
    .chan_flags (chan_flags)
  );

  for (genvar i = 0; i < num_chan; i++) begin : g_chan
    async_fifo u_fifo (
      .wr_clk    (wr_clk),
      .wr_rst_n  (wr_rst_n),
      .push      (push[i]),
      .push_data (push_data),
      .flags     (chan_flags[i]),
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .pop       (pop[i]),
      .empty     (empty[i]),
      .pop_data  (pop_data[i])
    );
  end

  rr_drain_arbiter u_arbiter (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .empty     (empty),
    .pop       (pop),
    .pop_data  (pop_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_item  (out_item)
  );

endmodule

`default_nettype wire

// ==== hw/rr_drain_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rr_drain_arbiter (
  input  wire                                rd_clk,
  input  wire                                rd_rst_n,
  input  wire [mailbox_pkg::num_chan-1:0]    empty,
  output logic [mailbox_pkg::num_chan-1:0]   pop,
  input  wire mailbox_pkg::chan_word_t       pop_data [mailbox_pkg::num_chan],
  output logic                               out_valid,
  input  wire                                out_ready,
  output mailbox_pkg::out_item_t             out_item
);
  import mailbox_pkg::*;

  logic [chan_width-1:0] last_chan;
  logic [chan_width-1:0] grant_chan;
  logic [chan_width-1:0] pend_chan;
  logic                  grant_valid;
  logic                  pend;
  logic                  pop_go;

  // search starts one past the channel served last.
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_chan = last_chan;
    for (int i = 1; i <= num_chan; i++) begin
      idx = (int'(last_chan) + i) % num_chan;
      if (!grant_valid && !empty[idx]) begin
        grant_valid = 1'b1;
        grant_chan = idx[chan_width-1:0];
      end
    end
  end

  // a pop is only issued when the output register is sure to be free.
  assign pop_go = grant_valid && !pend && (!out_valid || out_ready);

  always_comb begin
    pop = '0;
    if (pop_go) begin
      pop[grant_chan] = 1'b1;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      last_chan <= chan_width'(num_chan - 1);
      pend <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      pend <= pop_go;
      if (pop_go) begin
        last_chan <= grant_chan;
      end
      if (pend) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (pop_go) begin
      pend_chan <= grant_chan;
    end
    if (pend) begin
      out_item.chan <= pend_chan;                  // ram output is valid one cycle after pop.
      out_item.data <= pop_data[pend_chan].data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axil_fifo_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_fifo_writer (
  input  wire                                     wr_clk,
  input  wire                                     wr_rst_n,
  input  wire                                     awvalid,
  output logic                                    awready,
  input  wire [mailbox_pkg::axil_addr_width-1:0]  awaddr,
  input  wire                                     wvalid,
  output logic                                    wready,
  input  wire [31:0]                              wdata,
  output logic                                    bvalid,
  input  wire                                     bready,
  output logic [1:0]                              bresp,
  input  wire                                     arvalid,
  output logic                                    arready,
  input  wire [mailbox_pkg::axil_addr_width-1:0]  araddr,
  output logic                                    rvalid,
  input  wire                                     rready,
  output logic [31:0]                             rdata,
  output logic [1:0]                              rresp,
  output logic [mailbox_pkg::num_chan-1:0]        push,
  output mailbox_pkg::chan_word_t                 push_data,
  input  wire mailbox_pkg::fifo_flags_t           chan_flags [mailbox_pkg::num_chan]
);
  import mailbox_pkg::*;

  logic [num_chan-1:0] wr_hit;
  logic                target_full;
  logic                wr_accept;
  logic                rd_accept;
  status_t             status;

  // ==================================================
  // write path
  // ==================================================
  assign wr_hit[0] = (awaddr == reg_chan0);
  assign wr_hit[1] = (awaddr == reg_chan1);

  always_comb begin
    target_full = 1'b0;
    for (int i = 0; i < num_chan; i++) begin
      if (wr_hit[i] && chan_flags[i].full) begin
        target_full = 1'b1;
      end
    end
  end

  assign wr_accept = awvalid && wvalid && (!bvalid || bready) && !target_full;
  assign awready = wr_accept;
  assign wready = wr_accept;
  assign push = wr_hit & {num_chan{wr_accept}};    // unmapped addresses push nothing.
  assign push_data = chan_word_t'(wdata[data_width-1:0]);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      bresp <= (|wr_hit) ? resp_okay : resp_slverr;
    end
  end

  // ==================================================
  // read path
  // ==================================================
  assign status.ch0 = chan_flags[0];
  assign status.ch1 = chan_flags[1];

  assign arready = !rvalid;                        // one read in flight at most.
  assign rd_accept = arvalid && arready;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (rd_accept) begin
      if (araddr == reg_status) begin
        rdata <= {{(32 - $bits(status_t)){1'b0}}, status};
        rresp <= resp_okay;
      end else begin
        rdata <= '0;
        rresp <= resp_slverr;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/async_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module async_fifo (
  input  wire                            wr_clk,
  input  wire                            wr_rst_n,
  input  wire                            push,
  input  wire mailbox_pkg::chan_word_t   push_data,
  output mailbox_pkg::fifo_flags_t       flags,
  input  wire                            rd_clk,
  input  wire                            rd_rst_n,
  input  wire                            pop,
  output logic                           empty,
  output mailbox_pkg::chan_word_t        pop_data
);
  import mailbox_pkg::*;

  logic [addr_width:0] wr_ptr;
  logic [addr_width:0] wr_ptr_nxt;
  logic [addr_width:0] wr_ptr_rsync;
  logic [addr_width:0] wr_used;

  logic [addr_width:0] rd_ptr;
  logic [addr_width:0] rd_ptr_nxt;
  logic [addr_width:0] rd_ptr_wsync;

  dualport_ram u_ram (
    .wr_clk  (wr_clk),
    .wr_en   (push),
    .wr_addr (wr_ptr[addr_width-1:0]),
    .wr_data (push_data),
    .rd_clk  (rd_clk),
    .rd_en   (pop),
    .rd_addr (rd_ptr[addr_width-1:0]),
    .rd_data (pop_data)
  );

  // the write pointer crosses into the read domain.
  gray_sync u_wr_to_rd (
    .src_clk   (wr_clk),
    .src_rst_n (wr_rst_n),
    .src_ptr   (wr_ptr_nxt),
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .dst_ptr   (wr_ptr_rsync)
  );

  // the read pointer crosses into the write domain.
  gray_sync u_rd_to_wr (
    .src_clk   (rd_clk),
    .src_rst_n (rd_rst_n),
    .src_ptr   (rd_ptr_nxt),
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .dst_ptr   (rd_ptr_wsync)
  );

  // ==================================================
  // write domain
  // ==================================================
  assign wr_ptr_nxt = push ? wr_ptr + 1'b1 : wr_ptr;
  assign wr_used = wr_ptr_nxt - rd_ptr_wsync;   // may overstate, never understate.

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
      flags <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
      flags.full <= (wr_ptr_nxt == {~rd_ptr_wsync[addr_width],
                                    rd_ptr_wsync[addr_width-1:0]});
      flags.afull <= (wr_used >= fifo_afull);
    end
  end

  // ==================================================
  // read domain
  // ==================================================
  assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
      empty <= 1'b1;
    end else begin
      rd_ptr <= rd_ptr_nxt;
      empty <= (rd_ptr_nxt == wr_ptr_rsync);    // lagging write pointer keeps this safe.
    end
  end

endmodule

`default_nettype wire

// ==== hw/gray_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module gray_sync (
  input  wire                               src_clk,
  input  wire                               src_rst_n,
  input  wire  [mailbox_pkg::addr_width:0]  src_ptr,
  input  wire                               dst_clk,
  input  wire                               dst_rst_n,
  output logic [mailbox_pkg::addr_width:0]  dst_ptr
);
  import mailbox_pkg::*;

  logic [addr_width:0] src_gray;
  logic [addr_width:0] sync_q1;
  logic [addr_width:0] sync_q2;

  function automatic logic [addr_width:0] gray_to_bin(input logic [addr_width:0] gray);
    logic [addr_width:0] bin;
    bin[addr_width] = gray[addr_width];
    for (int i = addr_width - 1; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

  // ==================================================
  // source side
  // ==================================================
  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      src_gray <= '0;
    end else begin
      src_gray <= src_ptr ^ (src_ptr >> 1);      // only one bit moves per step.
    end
  end

  // ==================================================
  // destination side
  // ==================================================
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= src_gray;                       // first stage may go metastable.
      sync_q2 <= sync_q1;
    end
  end

  assign dst_ptr = gray_to_bin(sync_q2);

endmodule

`default_nettype wire

// ==== hw/dualport_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module dualport_ram (
  input  wire                                 wr_clk,
  input  wire                                 wr_en,
  input  wire [mailbox_pkg::addr_width-1:0]   wr_addr,
  input  wire mailbox_pkg::chan_word_t        wr_data,
  input  wire                                 rd_clk,
  input  wire                                 rd_en,
  input  wire [mailbox_pkg::addr_width-1:0]   rd_addr,
  output mailbox_pkg::chan_word_t             rd_data
);
  import mailbox_pkg::*;

  chan_word_t mem [fifo_depth];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];                   // holds its value between reads.
    end
  end

endmodule

`default_nettype wire

// ==== hw/mailbox_pkg.sv ====
`default_nettype none

package mailbox_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int data_width = 16;
  localparam int fifo_depth = 16;
  localparam int addr_width = 4;                 // pointers carry one extra wrap bit.
  localparam int fifo_afull = 12;
  localparam int num_chan = 2;
  localparam int chan_width = $clog2(num_chan);

  // ==================================================
  // register map and responses
  // ==================================================
  localparam int axil_addr_width = 4;
  localparam logic [axil_addr_width-1:0] reg_chan0 = 4'h0;
  localparam logic [axil_addr_width-1:0] reg_chan1 = 4'h4;
  localparam logic [axil_addr_width-1:0] reg_status = 4'h8;
  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef struct packed {
    logic [data_width-1:0] data;
  } chan_word_t;

  typedef struct packed {
    logic [chan_width-1:0] chan;                 // source channel of the item.
    logic [data_width-1:0] data;
  } out_item_t;

  typedef struct packed {
    logic full;
    logic afull;
  } fifo_flags_t;

  typedef struct packed {
    fifo_flags_t ch1;
    fifo_flags_t ch0;
  } status_t;

endpackage

`default_nettype wire
